//--- Makefile
# Verilator build and run of the line-fill controller testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, fail unless the pass line appears"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f verilog.f --top-module cache_memctrl_tb -Mdir obj_dir
	./obj_dir/Vcache_memctrl_tb | tee /dev/stderr | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

//--- sim/cache_memctrl_tb.sv
// Testbench for the line-fill controller with reset, single fill, outstanding limit,
// flush and fill-during-flush tests

`timescale 1ns/1ps
`default_nettype none

module cache_memctrl_tb;

    import memctrl_pkg::*;

    logic              aclk;
    logic              aresetn;
    logic              mst_arvalid;
    logic              mst_arready;
    cache_addr_u       mst_araddr;
    logic [PROT_W-1:0] mst_arprot;
    logic [ID_W-1:0]   mst_arid;
    logic              mem_arvalid;
    logic              mem_arready;
    cache_addr_u       mem_araddr;
    logic [PROT_W-1:0] mem_arprot;
    logic              mem_rvalid;
    logic              mem_rready;
    logic [DATA_W-1:0] mem_rdata;
    logic              flush_blocks;
    logic              flushing;
    logic              flush_ack;
    logic              cache_loading;
    logic              cache_wen;
    cache_addr_u       cache_waddr;
    logic [DATA_W-1:0] cache_wdata;
    logic              stall;

    integer seed;
    int     errors;
    int     tests_run;
    int     cycles;

    cache_memctrl dut (.*);
    mem_responder u_mem_responder (.*);

    always #4 aclk = ~aclk;

    // Watchdog far beyond the length of the whole run
    always @(posedge aclk) begin
        cycles = cycles + 1;
        if (cycles >= 3000) begin
            $display("error: time %0t ns, run did not finish within 3000 cycles", $time);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and expected values
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] expected);
        $display("error: time %0t ns, %s = %0h, expected %0h", $time, name, got, expected);
        errors++;
    endtask

    // Block address of any byte address
    function automatic logic [ADDR_W-1:0] block_of(input logic [ADDR_W-1:0] addr);
        return {addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
    endfunction

    // Memory answers with the block address in every 16-bit lane
    function automatic logic [DATA_W-1:0] lane_data(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] data;
        for (int i = 0; i < DATA_W / 16; i++) begin
            data[i*16 +: 16] = 16'(block_of(addr));
        end
        return data;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Bus actions that start and end 1 ns after a falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic issue_request(input logic [ADDR_W-1:0] addr);
        @(negedge aclk);
        mst_arvalid     = 1'b1;
        mst_araddr.word = addr;
        mst_arprot      = PROT_W'($random(seed));
        mst_arid        = ID_W'($random(seed));
        #1;
        while (!mst_arready) begin
            @(negedge aclk);
            #1;
        end
        if (mem_araddr.word !== block_of(addr))
            report_mismatch("mem_araddr", DATA_W'(mem_araddr.word), DATA_W'(block_of(addr)));
        if (mem_arvalid !== 1'b1)
            report_mismatch("mem_arvalid", DATA_W'(mem_arvalid), DATA_W'(1'b1));
        if (mem_arprot !== mst_arprot)
            report_mismatch("mem_arprot", DATA_W'(mem_arprot), DATA_W'(mst_arprot));
        // Handshake on the rising edge in between
        @(negedge aclk);
        mst_arvalid = 1'b0;
        #1;
        if (cache_loading !== 1'b1)
            report_mismatch("cache_loading", DATA_W'(cache_loading), DATA_W'(1'b1));
    endtask

    task automatic wait_fill(input logic [ADDR_W-1:0] addr);
        while (!cache_wen) begin
            @(negedge aclk);
            #1;
        end
        if (flushing !== 1'b0)
            report_mismatch("flushing", DATA_W'(flushing), DATA_W'(1'b0));
        if (cache_waddr.word !== block_of(addr))
            report_mismatch("cache_waddr", DATA_W'(cache_waddr.word), DATA_W'(block_of(addr)));
        if (cache_wdata !== lane_data(addr))
            report_mismatch("cache_wdata", cache_wdata, lane_data(addr));
        @(negedge aclk);
        #1;
    endtask

    // Raise the flush request and follow the erase until flushing drops
    task automatic run_flush(input bit free_stall);
        int erases;
        erases = 0;
        @(negedge aclk);
        flush_blocks = 1'b1;
        @(negedge aclk);
        if (free_stall)
            stall = 1'b0;
        #1;
        if (!flushing) begin
            $display("error: time %0t ns, flushing did not rise after the request", $time);
            errors++;
        end
        while (flushing) begin
            if (cache_wen !== 1'b1)
                report_mismatch("cache_wen", DATA_W'(cache_wen), DATA_W'(1'b1));
            if (cache_waddr.word !== ADDR_W'(erases * 16))
                report_mismatch("cache_waddr", DATA_W'(cache_waddr.word), DATA_W'(erases * 16));
            if (cache_wdata !== '0)
                report_mismatch("cache_wdata", cache_wdata, '0);
            if (mem_rready !== 1'b0)
                report_mismatch("mem_rready", DATA_W'(mem_rready), DATA_W'(1'b0));
            erases++;
            @(negedge aclk);
            #1;
        end
        if (erases != 64)
            report_mismatch("erase count", DATA_W'(erases), DATA_W'(64));
        if (flush_ack !== 1'b1)
            report_mismatch("flush_ack", DATA_W'(flush_ack), DATA_W'(1'b1));
    endtask

    task automatic release_flush();
        @(negedge aclk);
        flush_blocks = 1'b0;
        #1;
        if (flush_ack !== 1'b1)
            report_mismatch("flush_ack", DATA_W'(flush_ack), DATA_W'(1'b1));
        @(negedge aclk);
        #1;
        if (flush_ack !== 1'b0)
            report_mismatch("flush_ack", DATA_W'(flush_ack), DATA_W'(1'b0));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        tests_run++;
        if ({flushing, flush_ack, cache_loading, cache_wen, mem_rready} !== 5'b0)
            report_mismatch("status after reset", DATA_W'({flushing, flush_ack,
                            cache_loading, cache_wen, mem_rready}), '0);
    endtask

    task automatic test_single_fills();
        logic [ADDR_W-1:0] addr;
        tests_run++;
        repeat (20) begin
            addr = ADDR_W'($random(seed));
            issue_request(addr);
            wait_fill(addr);
            if (cache_loading !== 1'b0)
                report_mismatch("cache_loading", DATA_W'(cache_loading), DATA_W'(1'b0));
        end
    endtask

    task automatic test_outstanding_limit();
        logic [ADDR_W-1:0] addrs [5];
        tests_run++;
        for (int i = 0; i < 5; i++) begin
            addrs[i] = ADDR_W'($random(seed));
        end
        @(negedge aclk);
        stall = 1'b1;
        for (int i = 0; i < 4; i++) begin
            issue_request(addrs[i]);
        end
        // Fifth request has no free slot
        @(negedge aclk);
        mst_arvalid     = 1'b1;
        mst_araddr.word = addrs[4];
        #1;
        repeat (3) begin
            if (mst_arready !== 1'b0)
                report_mismatch("mst_arready", DATA_W'(mst_arready), DATA_W'(1'b0));
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
        mst_arvalid = 1'b0;
        stall       = 1'b0;
        #1;
        for (int i = 0; i < 4; i++) begin
            wait_fill(addrs[i]);
        end
        issue_request(addrs[4]);
        wait_fill(addrs[4]);
    endtask

    task automatic test_flush();
        tests_run++;
        run_flush(1'b0);
        if (cache_wen !== 1'b0)
            report_mismatch("cache_wen", DATA_W'(cache_wen), DATA_W'(1'b0));
        // Acknowledge holds while the request stays high
        repeat (3) begin
            @(negedge aclk);
            #1;
            if (flush_ack !== 1'b1)
                report_mismatch("flush_ack", DATA_W'(flush_ack), DATA_W'(1'b1));
        end
        release_flush();
    endtask

    task automatic test_fill_during_flush();
        logic [ADDR_W-1:0] addr;
        tests_run++;
        addr = ADDR_W'($random(seed));
        @(negedge aclk);
        stall = 1'b1;
        issue_request(addr);
        // Data becomes available only once the erase has begun
        run_flush(1'b1);
        wait_fill(addr);
        release_flush();
    endtask

    initial begin
        seed          = 92314;
        errors        = 0;
        tests_run     = 0;
        cycles        = 0;
        aclk          = 1'b0;
        aresetn       = 1'b0;
        mst_arvalid   = 1'b0;
        mst_araddr    = '0;
        mst_arprot    = '0;
        mst_arid      = '0;
        flush_blocks  = 1'b0;
        stall         = 1'b0;
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        #1;
        test_reset_state();
        test_single_fills();
        test_outstanding_limit();
        test_flush();
        test_fill_during_flush();
        @(negedge aclk);
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/mem_responder.sv
// Behavioral central memory, in-order single-beat reads with a
// read-data stall input

`timescale 1ns/1ps
`default_nettype none

module mem_responder (
    input  wire                            aclk,
    input  wire                            aresetn,
    // Withholds read data while high
    input  wire                            stall,
    // Read address channel
    input  wire                            mem_arvalid,
    output logic                           mem_arready,
    input  wire memctrl_pkg::cache_addr_u  mem_araddr,
    // Read data channel
    output logic                           mem_rvalid,
    input  wire                            mem_rready,
    output logic [memctrl_pkg::DATA_W-1:0] mem_rdata
);

    import memctrl_pkg::*;

    // Pending read addresses, oldest at rd_ptr
    logic [ADDR_W-1:0] pend [OSTD_NUM];
    logic [OSTD_W-1:0] wr_ptr;
    logic [OSTD_W-1:0] rd_ptr;
    logic [OSTD_W:0]   count;
    logic              ar_hs;
    logic              r_hs;
    // Address as seen in each 16-bit data lane
    logic [15:0]       lane;

    // Every read address is taken at once
    assign mem_arready = 1'b1;
    assign ar_hs       = mem_arvalid && mem_arready;
    assign r_hs        = mem_rvalid && mem_rready;

    always_ff @(posedge aclk) begin
        if (ar_hs) begin
            pend[wr_ptr] <= mem_araddr.word;
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (ar_hs) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (r_hs) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (ar_hs && !r_hs) begin
                count <= count + 1'b1;
            end else if (!ar_hs && r_hs) begin
                count <= count - 1'b1;
            end
        end
    end

    // Oldest address replicated over the whole beat
    assign lane       = 16'(pend[rd_ptr]);
    assign mem_rvalid = (count != '0) && !stall;
    assign mem_rdata  = {(DATA_W / 16){lane}};

endmodule

`default_nettype wire

//--- src/cache_memctrl.sv
// Line-fill memory controller top, read path and flush control

`timescale 1ns/1ps
`default_nettype none

module cache_memctrl (
    input  wire                            aclk,
    input  wire                            aresetn,
    // Fetch side read address, ID is not forwarded
    input  wire                            mst_arvalid,
    output logic                           mst_arready,
    input  wire memctrl_pkg::cache_addr_u  mst_araddr,
    input  wire [memctrl_pkg::PROT_W-1:0]  mst_arprot,
    input  wire [memctrl_pkg::ID_W-1:0]    mst_arid,
    // Central memory read channels, single full-width beat per request
    output logic                           mem_arvalid,
    input  wire                            mem_arready,
    output memctrl_pkg::cache_addr_u       mem_araddr,
    output logic [memctrl_pkg::PROT_W-1:0] mem_arprot,
    input  wire                            mem_rvalid,
    output logic                           mem_rready,
    input  wire [memctrl_pkg::DATA_W-1:0]  mem_rdata,
    // Flush interface
    input  wire                            flush_blocks,
    output logic                           flushing,
    output logic                           flush_ack,
    // Cache block write port
    output logic                           cache_loading,
    output logic                           cache_wen,
    output memctrl_pkg::cache_addr_u       cache_waddr,
    output logic [memctrl_pkg::DATA_W-1:0] cache_wdata
);

    import memctrl_pkg::*;

    // Fill write from the read path to the port select
    logic              fill_wen;
    cache_addr_u       fill_addr;
    logic [DATA_W-1:0] fill_data;

    read_request u_read_request (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .mst_arvalid   (mst_arvalid),
        .mst_arready   (mst_arready),
        .mst_araddr    (mst_araddr),
        .mst_arprot    (mst_arprot),
        .mem_arvalid   (mem_arvalid),
        .mem_arready   (mem_arready),
        .mem_araddr    (mem_araddr),
        .mem_arprot    (mem_arprot),
        .mem_rvalid    (mem_rvalid),
        .mem_rready    (mem_rready),
        .mem_rdata     (mem_rdata),
        .flushing      (flushing),
        .cache_loading (cache_loading),
        .fill_wen      (fill_wen),
        .fill_addr     (fill_addr),
        .fill_data     (fill_data)
    );

    flush_ctrl u_flush_ctrl (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .flush_blocks (flush_blocks),
        .flushing     (flushing),
        .flush_ack    (flush_ack),
        .fill_wen     (fill_wen),
        .fill_addr    (fill_addr),
        .fill_data    (fill_data),
        .cache_wen    (cache_wen),
        .cache_waddr  (cache_waddr),
        .cache_wdata  (cache_wdata)
    );

endmodule

`default_nettype wire

//--- src/flush_ctrl.sv
// Flush FSM with block eraser, and the cache write port select
// between erase writes and fill writes

`timescale 1ns/1ps
`default_nettype none

module flush_ctrl (
    input  wire                           aclk,
    input  wire                           aresetn,
    // Flush request level and status
    input  wire                           flush_blocks,
    output logic                          flushing,
    output logic                          flush_ack,
    // Fill write from the read path
    input  wire                           fill_wen,
    input  wire memctrl_pkg::cache_addr_u fill_addr,
    input  wire [memctrl_pkg::DATA_W-1:0] fill_data,
    // Cache block write port
    output logic                          cache_wen,
    output memctrl_pkg::cache_addr_u      cache_waddr,
    output logic [memctrl_pkg::DATA_W-1:0] cache_wdata
);

    import memctrl_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ERASE = 2'd1,
        ST_ACK   = 2'd2
    } flush_state_t;

    flush_state_t       state;
    // Block being erased this cycle
    logic [INDEX_W-1:0] erase_idx;
    cache_addr_u        erase_addr;
    logic               last_block;

    assign last_block = (erase_idx == INDEX_W'(CACHE_DEPTH - 1));

    //////////////////////////////////////////////////////////////////////
    // Flush FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= ST_IDLE;
            flushing  <= 1'b0;
            flush_ack <= 1'b0;
            erase_idx <= '0;
        end else begin
            case (state)
                // Wait for the core to request a flush
                ST_IDLE: begin
                    if (flush_blocks) begin
                        state     <= ST_ERASE;
                        flushing  <= 1'b1;
                        erase_idx <= '0;
                    end
                end
                // One block per cycle, index wraps to zero after the last
                ST_ERASE: begin
                    erase_idx <= erase_idx + 1'b1;
                    if (last_block) begin
                        state     <= ST_ACK;
                        flushing  <= 1'b0;
                        flush_ack <= 1'b1;
                    end
                end
                // Hold the acknowledge until the request drops
                ST_ACK: begin
                    if (!flush_blocks) begin
                        state     <= ST_IDLE;
                        flush_ack <= 1'b0;
                    end
                end
                default: begin
                    state     <= ST_IDLE;
                    flushing  <= 1'b0;
                    flush_ack <= 1'b0;
                end
            endcase
        end
    end

    // Erase address is the index with a zero offset
    always_comb begin
        erase_addr               = '0;
        erase_addr.fields.index  = erase_idx;
        erase_addr.fields.offset = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Cache write port select
    //////////////////////////////////////////////////////////////////////

    // Eraser owns the port for the whole flush
    assign cache_wen   = flushing ? 1'b1 : fill_wen;
    assign cache_waddr = flushing ? erase_addr : fill_addr;
    assign cache_wdata = flushing ? '0 : fill_data;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Acknowledge only after the erase is over
    a_flush_ack_excl : assert property (
        @(posedge aclk) disable iff (!aresetn)
        !(flushing && flush_ack)
    );

    // Erase writes land on block boundaries, one block apart
    a_erase_aligned : assert property (
        @(posedge aclk) disable iff (!aresetn)
        flushing && $past(flushing) |->
            cache_waddr.fields.offset == '0 &&
            cache_waddr.word == $past(cache_waddr.word) + ADDR_W'(BLOCK_BYTES)
    );

    // Read path holds data ready low, so no fill competes with the eraser
    a_no_fill_in_flush : assert property (
        @(posedge aclk) disable iff (!aresetn)
        flushing |-> !fill_wen
    );

endmodule

`default_nettype wire

//--- src/memctrl_pkg.sv
// Shared sizes, cache geometry and the address union of the
// instruction-cache line-fill controller

`default_nettype none

package memctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////////////////////////

    // Byte address, same width on fetch and memory sides
    localparam int ADDR_W = 10;
    // Memory read data, one full cache block per beat
    localparam int DATA_W = 128;
    // Fetch request ID, accepted and dropped
    localparam int ID_W = 8;
    // AXI protection field
    localparam int PROT_W = 3;

    //////////////////////////////////////////////////////////////////////
    // Cache geometry
    //////////////////////////////////////////////////////////////////////

    // Bytes per block, also the erase address step
    localparam int BLOCK_BYTES = DATA_W / 8;
    // Byte offset bits inside a block
    localparam int OFFSET_W = $clog2(BLOCK_BYTES);
    // Number of blocks
    // 64 blocks of 16 bytes cover the whole 10-bit space
    localparam int CACHE_DEPTH = 64;
    // Block index bits
    localparam int INDEX_W = $clog2(CACHE_DEPTH);

    //////////////////////////////////////////////////////////////////////
    // Outstanding read tracking
    //////////////////////////////////////////////////////////////////////

    // Reads in flight toward central memory
    localparam int OSTD_NUM = 4;
    // FIFO pointer width
    localparam int OSTD_W = $clog2(OSTD_NUM);

    //////////////////////////////////////////////////////////////////////
    // Address word, seen as a byte address or as index and offset
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef union packed {
        // Plain byte address
        logic [ADDR_W-1:0] word;
        // Block index above byte offset
        cache_addr_t       fields;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- src/read_request.sv
// Read request forwarding, outstanding address tracking and
// conversion of read beats into cache fill writes

`timescale 1ns/1ps
`default_nettype none

module read_request (
    input  wire                           aclk,
    input  wire                           aresetn,
    // Fetch side read address
    input  wire                           mst_arvalid,
    output logic                          mst_arready,
    input  wire memctrl_pkg::cache_addr_u mst_araddr,
    input  wire [memctrl_pkg::PROT_W-1:0] mst_arprot,
    // Memory read address
    output logic                          mem_arvalid,
    input  wire                           mem_arready,
    output memctrl_pkg::cache_addr_u      mem_araddr,
    output logic [memctrl_pkg::PROT_W-1:0] mem_arprot,
    // Memory read data
    input  wire                           mem_rvalid,
    output logic                          mem_rready,
    input  wire [memctrl_pkg::DATA_W-1:0] mem_rdata,
    // Flush in progress
    input  wire                           flushing,
    // Fill status and fill write
    output logic                          cache_loading,
    output logic                          fill_wen,
    output memctrl_pkg::cache_addr_u      fill_addr,
    output logic [memctrl_pkg::DATA_W-1:0] fill_data
);

    import memctrl_pkg::*;

    // FIFO status and oldest recorded address
    logic        fifo_full;
    logic        fifo_empty;
    cache_addr_u ostd_addr;

    // Handshakes
    logic ar_hs;
    logic r_hs;

    //////////////////////////////////////////////////////////////////////
    // Read address channel
    //////////////////////////////////////////////////////////////////////

    // No request leaves while all tracking slots are taken
    assign mem_arvalid = mst_arvalid && !fifo_full;
    assign mst_arready = mem_arready && !fifo_full;
    assign mem_arprot  = mst_arprot;

    // Block-aligned address toward memory
    always_comb begin
        mem_araddr               = mst_araddr;
        mem_araddr.fields.offset = '0;
    end

    assign ar_hs = mst_arvalid && mst_arready;

    //////////////////////////////////////////////////////////////////////
    // Outstanding addresses, oldest first
    //////////////////////////////////////////////////////////////////////

    sync_fifo u_ostd_fifo (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .push     (ar_hs),
        .data_in  (mst_araddr),
        .full     (fifo_full),
        .pull     (r_hs),
        .data_out (ostd_addr),
        .empty    (fifo_empty)
    );

    //////////////////////////////////////////////////////////////////////
    // Read data channel and fill write
    //////////////////////////////////////////////////////////////////////

    // Data waits in memory while the eraser owns the cache port
    assign mem_rready = !fifo_empty && !flushing;
    assign r_hs       = mem_rvalid && mem_rready;

    // One beat, one block written at the recorded address
    assign fill_wen  = r_hs;
    assign fill_data = mem_rdata;

    always_comb begin
        fill_addr               = ostd_addr;
        fill_addr.fields.offset = '0;
    end

    //////////////////////////////////////////////////////////////////////
    // Fill pending flag
    //////////////////////////////////////////////////////////////////////

    // New request wins over a completing one
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cache_loading <= 1'b0;
        end else if (ar_hs) begin
            cache_loading <= 1'b1;
        end else if (r_hs) begin
            cache_loading <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/sync_fifo.sv
// Single-clock FIFO holding the addresses of outstanding reads

`timescale 1ns/1ps
`default_nettype none

module sync_fifo (
    input  wire                      aclk,
    input  wire                      aresetn,
    input  wire                      push,
    input  wire memctrl_pkg::cache_addr_u data_in,
    output logic                     full,
    input  wire                      pull,
    output memctrl_pkg::cache_addr_u data_out,
    output logic                     empty
);

    import memctrl_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // Storage and pointers
    //////////////////////////////////////////////////////////////////////

    // Entry array, payload only
    cache_addr_u       mem [OSTD_NUM];
    // Next slot to write
    logic [OSTD_W-1:0] wr_ptr;
    // Oldest entry
    logic [OSTD_W-1:0] rd_ptr;
    // Occupancy, one bit wider than the pointers
    logic [OSTD_W:0]   count;

    // Write side
    always_ff @(posedge aclk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    // Pointers and count, wrap naturally on power-of-two depth
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pull keeps the level
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Status and read port
    //////////////////////////////////////////////////////////////////////

    assign full  = (count == (OSTD_W + 1)'(OSTD_NUM));
    assign empty = (count == '0);

    // Oldest entry shown without a read latency
    assign data_out = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Requester must stall on full, a push here would drop a fill address
    a_no_push_full : assert property (
        @(posedge aclk) disable iff (!aresetn)
        push |-> !full
    );

    // A data beat without a recorded address has nowhere to go
    a_no_pull_empty : assert property (
        @(posedge aclk) disable iff (!aresetn)
        pull |-> !empty
    );

endmodule

`default_nettype wire

//--- verilog.f
src/memctrl_pkg.sv
src/sync_fifo.sv
src/read_request.sv
src/flush_ctrl.sv
src/cache_memctrl.sv
sim/mem_responder.sv
sim/cache_memctrl_tb.sv
